//--- issue_params.svh
// width and count macros for the issue and read-operands stage
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------
// integer data word
`define ISSUE_XLEN 32
// program counter
`define ISSUE_VLEN 32
// register index into the integer file
`define ISSUE_REG_ADDR_W 5
// operation code handed to execute
`define ISSUE_OP_W 7
// scoreboard tag
`define ISSUE_TRANS_ID_W 3

// ----------------------------------------
// counts
// ----------------------------------------
`define ISSUE_NR_REGS 32
// write ports coming back from commit
`define ISSUE_NR_COMMIT 2
// source operand lanes (rs1, rs2)
`define ISSUE_NR_OPERANDS 2

`endif

//--- issue_pkg.sv
// vector typedefs, functional-unit enum and packed structs of the issue stage
`include "issue_params.svh"

package issue_pkg;

  // ----------------------------------------
  // plain vectors
  // ----------------------------------------
  typedef logic [`ISSUE_XLEN-1:0]       xlen_t;
  typedef logic [`ISSUE_VLEN-1:0]       vaddr_t;
  typedef logic [`ISSUE_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`ISSUE_OP_W-1:0]       op_t;
  typedef logic [`ISSUE_TRANS_ID_W-1:0] trans_id_t;

  // unit that executes (or still has to write back) an instruction
  typedef enum logic [2:0] {
    NONE,
    LOAD,
    STORE,
    ALU,
    CTRL_FLOW,
    MULT,
    CSR
  } fu_t;

  // ----------------------------------------
  // structs
  // ----------------------------------------
  // one scoreboard entry offered for issue
  typedef struct packed {
    fu_t       fu;
    op_t       op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    // immediate from decode
    xlen_t     result;
    logic      use_imm;
    logic      use_zimm;
    logic      use_pc;
    vaddr_t    pc;
    logic      is_compressed;
    trans_id_t trans_id;
    // exception already raised upstream
    logic      ex_valid;
  } sb_entry_t;

  // payload for the execute stage
  typedef struct packed {
    fu_t       fu;
    op_t       operation;
    xlen_t     operand_a;
    xlen_t     operand_b;
    xlen_t     imm;
    trans_id_t trans_id;
  } fu_data_t;

  // one start strobe per execute unit
  typedef struct packed {
    logic alu;
    logic branch;
    logic lsu;
    logic mult;
    logic csr;
  } fu_valid_t;

  // single write port from commit
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    xlen_t     wdata;
  } commit_port_t;

  // pending writer per architectural register
  typedef fu_t [`ISSUE_NR_REGS-1:0] clobber_table_t;

endpackage

//--- int_regfile.sv
// integer register file with combinational reads, commit write ports and x0 tied to zero
`timescale 1ns/10ps
`include "issue_params.svh"

module int_regfile (
  input  logic                                              clk_i,
  input  logic                                              rst_uarch_ni,
  // write ports from commit
  input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT-1:0]    commit_i,
  // one read port per operand lane
  input  issue_pkg::reg_addr_t    [`ISSUE_NR_OPERANDS-1:0]  raddr_i,
  output issue_pkg::xlen_t        [`ISSUE_NR_OPERANDS-1:0]  rdata_o
);

  // x1..x31 only, x0 has no storage
  issue_pkg::xlen_t mem_q [1:`ISSUE_NR_REGS-1];

  // ----------------------------------------
  // write side
  // ----------------------------------------
  // ports are walked in order so the highest port wins on a shared address
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      for (int r = 1; r < `ISSUE_NR_REGS; r++) begin
        mem_q[r] <= '0;
      end
    end else begin
      for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
        // writes to x0 are dropped
        if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
          mem_q[commit_i[p].waddr] <= commit_i[p].wdata;
        end
      end
    end
  end

  // ----------------------------------------
  // read side
  // ----------------------------------------
  // a same-cycle write is not bypassed, the old value comes out
  always_comb begin
    for (int i = 0; i < `ISSUE_NR_OPERANDS; i++) begin
      if (raddr_i[i] == '0) begin
        rdata_o[i] = '0;
      end else begin
        rdata_o[i] = mem_q[raddr_i[i]];
      end
    end
  end

endmodule

//--- operand_lane.sv
// source operand lane with clobber lookup, forward or stall decision and operand select
`timescale 1ns/10ps
`include "issue_params.svh"

module operand_lane #(
  // 0 picks rs1, 1 picks rs2
  parameter int OPERAND_IDX = 0
) (
  input  issue_pkg::sb_entry_t      issue_instr_i,
  input  issue_pkg::clobber_table_t rd_clobber_i,
  // scoreboard answer to the poll
  input  issue_pkg::xlen_t          sb_data_i,
  input  logic                      sb_valid_i,
  // register file read data
  input  issue_pkg::xlen_t          rf_data_i,
  output issue_pkg::reg_addr_t      rs_addr_o,
  output issue_pkg::xlen_t          operand_o,
  output logic                      stall_o
);

  issue_pkg::fu_t clobber_fu;
  logic           has_dep;

  // source field, shared by scoreboard poll and regfile read
  assign rs_addr_o  = (OPERAND_IDX == 0) ? issue_instr_i.rs1 : issue_instr_i.rs2;
  assign clobber_fu = rd_clobber_i[rs_addr_o];

  // zimm in rs1 is an immediate and waits on nothing
  assign has_dep = (clobber_fu != issue_pkg::NONE) &&
                   !((OPERAND_IDX == 0) && issue_instr_i.use_zimm);

  always_comb begin
    operand_o = rf_data_i;
    stall_o   = 1'b0;
    if (has_dep) begin
      // csr results only reach us through the register file
      if (sb_valid_i && (clobber_fu != issue_pkg::CSR)) begin
        operand_o = sb_data_i;
      end else begin
        stall_o = 1'b1;
      end
    end
  end

endmodule

//--- issue_control.sv
// structural busy, write-after-write check and issue acknowledge
`timescale 1ns/10ps
`include "issue_params.svh"

module issue_control (
  input  issue_pkg::sb_entry_t                           issue_instr_i,
  input  logic                                           issue_valid_i,
  input  issue_pkg::clobber_table_t                      rd_clobber_i,
  input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT-1:0] commit_i,
  // fixed-latency unit can take a new op
  input  logic                                           flu_ready_i,
  input  logic                                           lsu_ready_i,
  input  logic                                           stall_i,
  // a multiply left the register stage this cycle
  input  logic                                           mult_issued_i,
  // per-lane raw stall
  input  logic [`ISSUE_NR_OPERANDS-1:0]                  operand_stall_i,
  output logic                                           issue_ack_o,
  output logic                                           stall_issue_o
);

  logic fu_busy;
  logic stall_raw;
  logic stall_waw;

  // ----------------------------------------
  // structural hazards
  // ----------------------------------------
  always_comb begin
    case (issue_instr_i.fu)
      // these share the fixed-latency writeback with a multiply in flight
      issue_pkg::ALU,
      issue_pkg::CTRL_FLOW,
      issue_pkg::CSR: begin
        fu_busy = !flu_ready_i || mult_issued_i;
      end
      // back-to-back multiplies are fine
      issue_pkg::MULT: begin
        fu_busy = !flu_ready_i;
      end
      issue_pkg::LOAD,
      issue_pkg::STORE: begin
        fu_busy = !lsu_ready_i;
      end
      // NONE needs no unit
      default: begin
        fu_busy = 1'b0;
      end
    endcase
  end

  // ----------------------------------------
  // read-after-write
  // ----------------------------------------
  // external stall folds into the raw stall
  assign stall_raw     = stall_i || (|operand_stall_i);
  assign stall_issue_o = stall_raw;

  // ----------------------------------------
  // write-after-write
  // ----------------------------------------
  always_comb begin
    stall_waw = (rd_clobber_i[issue_instr_i.rd] != issue_pkg::NONE);
    // the old writer retires right now so rd frees up
    for (int c = 0; c < `ISSUE_NR_COMMIT; c++) begin
      if (commit_i[c].we && (commit_i[c].waddr == issue_instr_i.rd)) begin
        stall_waw = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // acknowledge
  // ----------------------------------------
  // exceptions and unit-less ops pass straight through, ignoring data hazards
  always_comb begin
    issue_ack_o = 1'b0;
    if (issue_valid_i && !fu_busy) begin
      if (!stall_raw && !stall_waw) begin
        issue_ack_o = 1'b1;
      end
      if (issue_instr_i.ex_valid) begin
        issue_ack_o = 1'b1;
      end
      if (issue_instr_i.fu == issue_pkg::NONE) begin
        issue_ack_o = 1'b1;
      end
    end
  end

endmodule

//--- issue_register.sv
// operand mux, ID/EX register, unit valids with flush, and control-flow PC register
`timescale 1ns/10ps
`include "issue_params.svh"

module issue_register (
  input  logic                  clk_i,
  input  logic                  rst_uarch_ni,
  input  logic                  flush_i,
  input  issue_pkg::sb_entry_t  issue_instr_i,
  input  logic                  issue_valid_i,
  input  logic                  issue_ack_i,
  // lane outputs, already forwarded or from the regfile
  input  issue_pkg::xlen_t      operand_a_i,
  input  issue_pkg::xlen_t      operand_b_i,
  output issue_pkg::fu_data_t   fu_data_o,
  output issue_pkg::fu_valid_t  fu_valid_o,
  output logic                  mult_issued_o,
  // unregistered operands
  output issue_pkg::xlen_t      rs1_forwarding_o,
  output issue_pkg::xlen_t      rs2_forwarding_o,
  output issue_pkg::vaddr_t     pc_o,
  output logic                  is_compressed_o
);

  issue_pkg::fu_data_t  fu_data_n;
  issue_pkg::fu_data_t  fu_data_q;
  issue_pkg::fu_valid_t fu_valid_q;

  // ----------------------------------------
  // operand mux
  // ----------------------------------------
  always_comb begin
    fu_data_n.fu        = issue_instr_i.fu;
    fu_data_n.operation = issue_instr_i.op;
    fu_data_n.trans_id  = issue_instr_i.trans_id;
    fu_data_n.imm       = issue_instr_i.result;
    fu_data_n.operand_a = operand_a_i;
    fu_data_n.operand_b = operand_b_i;
    // auipc / jal style
    if (issue_instr_i.use_pc) begin
      fu_data_n.operand_a = issue_pkg::xlen_t'(issue_instr_i.pc);
    end
    // csr immediate, zero extended rs1 field
    if (issue_instr_i.use_zimm) begin
      fu_data_n.operand_a = {{(`ISSUE_XLEN-`ISSUE_REG_ADDR_W){1'b0}}, issue_instr_i.rs1};
    end
    // stores and branches keep rs2 in operand b, imm goes separately
    if (issue_instr_i.use_imm &&
        (issue_instr_i.fu != issue_pkg::STORE) &&
        (issue_instr_i.fu != issue_pkg::CTRL_FLOW)) begin
      fu_data_n.operand_b = issue_instr_i.result;
    end
  end

  assign rs1_forwarding_o = fu_data_n.operand_a;
  assign rs2_forwarding_o = fu_data_n.operand_b;

  // ----------------------------------------
  // ID/EX register
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_uarch_ni) begin
    if (!rst_uarch_ni) begin
      fu_data_q       <= '0;
      fu_valid_q      <= '0;
      pc_o            <= '0;
      is_compressed_o <= 1'b0;
    end else begin
      fu_data_q  <= fu_data_n;
      fu_valid_q <= '0;
      // an instruction carrying an exception starts no unit
      if (issue_valid_i && issue_ack_i && !issue_instr_i.ex_valid) begin
        case (issue_instr_i.fu)
          issue_pkg::ALU:       fu_valid_q.alu    <= 1'b1;
          issue_pkg::CTRL_FLOW: fu_valid_q.branch <= 1'b1;
          issue_pkg::LOAD,
          issue_pkg::STORE:     fu_valid_q.lsu    <= 1'b1;
          issue_pkg::MULT:      fu_valid_q.mult   <= 1'b1;
          issue_pkg::CSR:       fu_valid_q.csr    <= 1'b1;
          default:              fu_valid_q        <= '0;
        endcase
      end
      // flush kills whatever was about to start
      if (flush_i) begin
        fu_valid_q <= '0;
      end
      // branch unit reads pc from here
      if (issue_instr_i.fu == issue_pkg::CTRL_FLOW) begin
        pc_o            <= issue_instr_i.pc;
        is_compressed_o <= issue_instr_i.is_compressed;
      end
    end
  end

  assign fu_data_o     = fu_data_q;
  assign fu_valid_o    = fu_valid_q;
  assign mult_issued_o = fu_valid_q.mult;

endmodule

//--- issue_read_operands.sv
// top of the issue and read-operands stage wiring regfile, operand lanes, control and register
`timescale 1ns/10ps
`include "issue_params.svh"

module issue_read_operands (
  input  logic                                           clk_i,
  input  logic                                           rst_uarch_ni,
  input  logic                                           flush_i,
  input  logic                                           stall_i,
  // scoreboard handshake
  input  issue_pkg::sb_entry_t                           issue_instr_i,
  input  logic                                           issue_valid_i,
  output logic                                           issue_ack_o,
  // operand poll
  output issue_pkg::reg_addr_t                           rs1_o,
  input  issue_pkg::xlen_t                               rs1_i,
  input  logic                                           rs1_valid_i,
  output issue_pkg::reg_addr_t                           rs2_o,
  input  issue_pkg::xlen_t                               rs2_i,
  input  logic                                           rs2_valid_i,
  input  issue_pkg::clobber_table_t                      rd_clobber_i,
  input  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT-1:0] commit_i,
  input  logic                                           flu_ready_i,
  input  logic                                           lsu_ready_i,
  // to execute
  output issue_pkg::fu_data_t                            fu_data_o,
  output issue_pkg::fu_valid_t                           fu_valid_o,
  output issue_pkg::xlen_t                               rs1_forwarding_o,
  output issue_pkg::xlen_t                               rs2_forwarding_o,
  output issue_pkg::vaddr_t                              pc_o,
  output logic                                           is_compressed_o,
  output logic                                           stall_issue_o
);

  issue_pkg::reg_addr_t [`ISSUE_NR_OPERANDS-1:0] rs_addr;
  issue_pkg::xlen_t     [`ISSUE_NR_OPERANDS-1:0] rf_data;
  issue_pkg::xlen_t     [`ISSUE_NR_OPERANDS-1:0] sb_data;
  logic                 [`ISSUE_NR_OPERANDS-1:0] sb_valid;
  issue_pkg::xlen_t     [`ISSUE_NR_OPERANDS-1:0] operand;
  logic                 [`ISSUE_NR_OPERANDS-1:0] operand_stall;
  logic                                          mult_issued;

  // lane 0 is rs1, lane 1 is rs2
  assign sb_data  = {rs2_i, rs1_i};
  assign sb_valid = {rs2_valid_i, rs1_valid_i};
  assign rs1_o    = rs_addr[0];
  assign rs2_o    = rs_addr[1];

  int_regfile int_regfile_inst (
    .clk_i        (clk_i),
    .rst_uarch_ni (rst_uarch_ni),
    .commit_i     (commit_i),
    .raddr_i      (rs_addr),
    .rdata_o      (rf_data)
  );

  // ----------------------------------------
  // operand lanes
  // ----------------------------------------
  for (genvar i = 0; i < `ISSUE_NR_OPERANDS; i++) begin : gen_lane
    operand_lane #(
      .OPERAND_IDX (i)
    ) operand_lane_inst (
      .issue_instr_i (issue_instr_i),
      .rd_clobber_i  (rd_clobber_i),
      .sb_data_i     (sb_data[i]),
      .sb_valid_i    (sb_valid[i]),
      .rf_data_i     (rf_data[i]),
      .rs_addr_o     (rs_addr[i]),
      .operand_o     (operand[i]),
      .stall_o       (operand_stall[i])
    );
  end

  issue_control issue_control_inst (
    .issue_instr_i   (issue_instr_i),
    .issue_valid_i   (issue_valid_i),
    .rd_clobber_i    (rd_clobber_i),
    .commit_i        (commit_i),
    .flu_ready_i     (flu_ready_i),
    .lsu_ready_i     (lsu_ready_i),
    .stall_i         (stall_i),
    .mult_issued_i   (mult_issued),
    .operand_stall_i (operand_stall),
    .issue_ack_o     (issue_ack_o),
    .stall_issue_o   (stall_issue_o)
  );

  issue_register issue_register_inst (
    .clk_i            (clk_i),
    .rst_uarch_ni     (rst_uarch_ni),
    .flush_i          (flush_i),
    .issue_instr_i    (issue_instr_i),
    .issue_valid_i    (issue_valid_i),
    .issue_ack_i      (issue_ack_o),
    .operand_a_i      (operand[0]),
    .operand_b_i      (operand[1]),
    .fu_data_o        (fu_data_o),
    .fu_valid_o       (fu_valid_o),
    .mult_issued_o    (mult_issued),
    .rs1_forwarding_o (rs1_forwarding_o),
    .rs2_forwarding_o (rs2_forwarding_o),
    .pc_o             (pc_o),
    .is_compressed_o  (is_compressed_o)
  );

endmodule

//--- issue_read_operands_checker.sv
// concurrent assertions on the issue stage ports and the bind that attaches them to the top
`timescale 1ns/10ps

module issue_read_operands_checker (
  input logic                 clk_i,
  input logic                 rst_uarch_ni,
  input logic                 flush_i,
  input logic                 issue_valid_i,
  input logic                 issue_ack_o,
  input issue_pkg::fu_valid_t fu_valid_o
);

  // failed assertion count
  int unsigned fail_cnt = 0;

  // at most one unit starts per cycle
  one_unit_a: assert property (@(posedge clk_i) disable iff (!rst_uarch_ni)
    $onehot0(fu_valid_o))
    else begin
      $error("more than one functional unit valid at once");
      fail_cnt++;
    end

  // flushed cycle starts nothing
  flush_kill_a: assert property (@(posedge clk_i) disable iff (!rst_uarch_ni)
    flush_i |=> (fu_valid_o == '0))
    else begin
      $error("unit valid set in the cycle after a flush");
      fail_cnt++;
    end

  // no handshake without an offered entry
  ack_valid_a: assert property (@(posedge clk_i) disable iff (!rst_uarch_ni)
    issue_ack_o |-> issue_valid_i)
    else begin
      $error("ack raised while issue valid is low");
      fail_cnt++;
    end

endmodule

bind issue_read_operands issue_read_operands_checker checker_inst (
  .clk_i         (clk_i),
  .rst_uarch_ni  (rst_uarch_ni),
  .flush_i       (flush_i),
  .issue_valid_i (issue_valid_i),
  .issue_ack_o   (issue_ack_o),
  .fu_valid_o    (fu_valid_o)
);

//--- tb_issue_read_operands.sv
// testbench for the issue and read-operands stage: clock, reset, lfsr stimulus, model, checks
`timescale 1ns/10ps
`include "issue_params.svh"

module tb_issue_read_operands;

  localparam int NUM_ACKS   = 1500;
  // generous budget of stalled cycles per handshake, 4 ns period
  localparam int TIMEOUT_NS = (NUM_ACKS * 40 + 20) * 4;

  logic                                           clk_i;
  logic                                           rst_uarch_ni;
  logic                                           flush_i;
  logic                                           stall_i;
  issue_pkg::sb_entry_t                           issue_instr_i;
  logic                                           issue_valid_i;
  logic                                           issue_ack_o;
  issue_pkg::reg_addr_t                           rs1_o;
  issue_pkg::xlen_t                               rs1_i;
  logic                                           rs1_valid_i;
  issue_pkg::reg_addr_t                           rs2_o;
  issue_pkg::xlen_t                               rs2_i;
  logic                                           rs2_valid_i;
  issue_pkg::clobber_table_t                      rd_clobber_i;
  issue_pkg::commit_port_t [`ISSUE_NR_COMMIT-1:0] commit_i;
  logic                                           flu_ready_i;
  logic                                           lsu_ready_i;
  issue_pkg::fu_data_t                            fu_data_o;
  issue_pkg::fu_valid_t                           fu_valid_o;
  issue_pkg::xlen_t                               rs1_forwarding_o;
  issue_pkg::xlen_t                               rs2_forwarding_o;
  issue_pkg::vaddr_t                              pc_o;
  logic                                           is_compressed_o;
  logic                                           stall_issue_o;

  // model state
  logic [31:0]          lfsr_q;
  issue_pkg::xlen_t     reg_model [0:`ISSUE_NR_REGS-1];
  issue_pkg::fu_valid_t exp_valid;
  issue_pkg::fu_data_t  exp_data;
  logic                 exp_data_chk;
  issue_pkg::vaddr_t    exp_pc;
  logic                 exp_compressed;
  int                   n_checks;
  int                   n_errors;
  int                   n_acks;

  issue_read_operands issue_read_operands_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // random source
  // ----------------------------------------
  // right-shifting galois form
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hA300_0000;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  // true once in 2**n
  function automatic logic rand_chance(input int n);
    return rand_bits(n) == 32'd0;
  endfunction

  // code 7 is unused, fold it onto ALU
  function automatic issue_pkg::fu_t to_fu(input logic [2:0] v);
    if (v == 3'd7) begin
      return issue_pkg::ALU;
    end
    return issue_pkg::fu_t'(v);
  endfunction

  task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
    n_checks++;
    assert (act === exp) else begin
      n_errors++;
      $display("Fail t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
    end
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  task automatic drive_inputs(input logic hold);
    for (int r = 0; r < `ISSUE_NR_REGS; r++) begin
      // roughly a quarter of the registers have a writer in flight
      if (rand_chance(2)) begin
        rd_clobber_i[r] = to_fu(3'(rand_bits(3)));
      end else begin
        rd_clobber_i[r] = issue_pkg::NONE;
      end
    end
    for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
      commit_i[p].we    = rand_bits(1) != 0;
      commit_i[p].waddr = issue_pkg::reg_addr_t'(rand_bits(5));
      commit_i[p].wdata = rand_bits(32);
    end
    // scoreboard keeps an unacknowledged entry on the bus
    if (!hold) begin
      issue_valid_i               = rand_bits(2) != 0;
      issue_instr_i.fu            = to_fu(3'(rand_bits(3)));
      issue_instr_i.op            = issue_pkg::op_t'(rand_bits(7));
      issue_instr_i.rs1           = issue_pkg::reg_addr_t'(rand_bits(5));
      issue_instr_i.rs2           = issue_pkg::reg_addr_t'(rand_bits(5));
      issue_instr_i.rd            = issue_pkg::reg_addr_t'(rand_bits(5));
      issue_instr_i.result        = rand_bits(32);
      issue_instr_i.use_imm       = rand_bits(1) != 0;
      issue_instr_i.use_zimm      = rand_chance(2);
      issue_instr_i.use_pc        = rand_chance(2);
      issue_instr_i.pc            = rand_bits(32);
      issue_instr_i.is_compressed = rand_bits(1) != 0;
      issue_instr_i.trans_id      = issue_pkg::trans_id_t'(rand_bits(3));
      issue_instr_i.ex_valid      = rand_chance(3);
    end
    // steer a commit onto rd now and then for the waw bypass
    if (rand_chance(2)) begin
      commit_i[1].we    = 1'b1;
      commit_i[1].waddr = issue_instr_i.rd;
    end
    rs1_i       = rand_bits(32);
    rs1_valid_i = rand_bits(2) != 0;
    rs2_i       = rand_bits(32);
    rs2_valid_i = rand_bits(2) != 0;
    flu_ready_i = !rand_chance(3);
    lsu_ready_i = !rand_chance(3);
    stall_i     = rand_chance(3);
    flush_i     = rand_chance(4);
  endtask

  // ----------------------------------------
  // reference model and checks
  // ----------------------------------------
  // registered outputs hold what the previous cycle handed off
  task automatic check_registered();
    check_val("fu_valid_o", 128'(exp_valid), 128'(fu_valid_o));
    check_val("pc_o", 128'(exp_pc), 128'(pc_o));
    check_val("is_compressed_o", 128'(exp_compressed), 128'(is_compressed_o));
    if (exp_data_chk) begin
      check_val("fu_data_o", 128'(exp_data), 128'(fu_data_o));
    end
  endtask

  task automatic check_cycle(output logic hold);
    issue_pkg::sb_entry_t in;
    issue_pkg::xlen_t     opnd [0:1];
    logic [1:0]           lane_stall;
    issue_pkg::reg_addr_t addr;
    issue_pkg::fu_t       cf;
    logic                 busy;
    logic                 raw;
    logic                 waw;
    logic                 ack;
    issue_pkg::xlen_t     a;
    issue_pkg::xlen_t     b;
    issue_pkg::fu_valid_t nxt_valid;
    in = issue_instr_i;
    check_registered();
    // per source: regfile value, forwarded value, or stall
    for (int k = 0; k < `ISSUE_NR_OPERANDS; k++) begin
      addr          = (k == 0) ? in.rs1 : in.rs2;
      cf            = rd_clobber_i[addr];
      opnd[k]       = (addr == '0) ? '0 : reg_model[addr];
      lane_stall[k] = 1'b0;
      if ((cf != issue_pkg::NONE) && !((k == 0) && in.use_zimm)) begin
        if (((k == 0) ? rs1_valid_i : rs2_valid_i) && (cf != issue_pkg::CSR)) begin
          opnd[k] = (k == 0) ? rs1_i : rs2_i;
        end else begin
          lane_stall[k] = 1'b1;
        end
      end
    end
    raw  = stall_i || (|lane_stall);
    busy = ((in.fu inside {issue_pkg::ALU, issue_pkg::CTRL_FLOW, issue_pkg::CSR,
                           issue_pkg::MULT}) && !flu_ready_i) ||
           ((in.fu inside {issue_pkg::ALU, issue_pkg::CTRL_FLOW, issue_pkg::CSR}) &&
            exp_valid.mult) ||
           ((in.fu inside {issue_pkg::LOAD, issue_pkg::STORE}) && !lsu_ready_i);
    waw = rd_clobber_i[in.rd] != issue_pkg::NONE;
    for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
      if (commit_i[p].we && (commit_i[p].waddr == in.rd)) begin
        waw = 1'b0;
      end
    end
    ack = issue_valid_i && !busy &&
          ((!raw && !waw) || in.ex_valid || (in.fu == issue_pkg::NONE));
    // operand mux, later rules override earlier ones
    a = opnd[0];
    if (in.use_pc) begin
      a = in.pc;
    end
    if (in.use_zimm) begin
      a = issue_pkg::xlen_t'(in.rs1);
    end
    b = opnd[1];
    if (in.use_imm && !(in.fu inside {issue_pkg::STORE, issue_pkg::CTRL_FLOW})) begin
      b = in.result;
    end
    check_val("issue_ack_o", 128'(ack), 128'(issue_ack_o));
    check_val("stall_issue_o", 128'(raw), 128'(stall_issue_o));
    check_val("rs1_o", 128'(in.rs1), 128'(rs1_o));
    check_val("rs2_o", 128'(in.rs2), 128'(rs2_o));
    check_val("rs1_forwarding_o", 128'(a), 128'(rs1_forwarding_o));
    check_val("rs2_forwarding_o", 128'(b), 128'(rs2_forwarding_o));
    // expected handoff for the next cycle
    nxt_valid = '0;
    if (ack && !in.ex_valid) begin
      nxt_valid.alu    = in.fu == issue_pkg::ALU;
      nxt_valid.branch = in.fu == issue_pkg::CTRL_FLOW;
      nxt_valid.lsu    = in.fu inside {issue_pkg::LOAD, issue_pkg::STORE};
      nxt_valid.mult   = in.fu == issue_pkg::MULT;
      nxt_valid.csr    = in.fu == issue_pkg::CSR;
    end
    if (flush_i) begin
      nxt_valid = '0;
    end
    exp_valid          = nxt_valid;
    exp_data_chk       = ack && !in.ex_valid;
    exp_data.fu        = in.fu;
    exp_data.operation = in.op;
    exp_data.operand_a = a;
    exp_data.operand_b = b;
    exp_data.imm       = in.result;
    exp_data.trans_id  = in.trans_id;
    if (in.fu == issue_pkg::CTRL_FLOW) begin
      exp_pc         = in.pc;
      exp_compressed = in.is_compressed;
    end
    if (issue_valid_i && issue_ack_o) begin
      n_acks++;
    end
    hold = issue_valid_i && !issue_ack_o;
    // commits land at the coming edge, higher port last
    for (int p = 0; p < `ISSUE_NR_COMMIT; p++) begin
      if (commit_i[p].we && (commit_i[p].waddr != '0)) begin
        reg_model[commit_i[p].waddr] = commit_i[p].wdata;
      end
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    logic hold;
    lfsr_q         = 32'h5bd90750;
    rst_uarch_ni   = 1'b0;
    flush_i        = 1'b0;
    stall_i        = 1'b0;
    issue_instr_i  = '0;
    issue_valid_i  = 1'b0;
    rs1_i          = '0;
    rs1_valid_i    = 1'b0;
    rs2_i          = '0;
    rs2_valid_i    = 1'b0;
    rd_clobber_i   = '0;
    commit_i       = '0;
    flu_ready_i    = 1'b1;
    lsu_ready_i    = 1'b1;
    exp_valid      = '0;
    exp_data       = '0;
    exp_data_chk   = 1'b0;
    exp_pc         = '0;
    exp_compressed = 1'b0;
    n_checks       = 0;
    n_errors       = 0;
    n_acks         = 0;
    hold           = 1'b0;
    for (int r = 0; r < `ISSUE_NR_REGS; r++) begin
      reg_model[r] = '0;
    end
    repeat (4) @(posedge clk_i);
    #1;
    rst_uarch_ni = 1'b1;
    while (n_acks < NUM_ACKS) begin
      @(posedge clk_i);
      #1;
      drive_inputs(hold);
      #2;
      check_cycle(hold);
    end
    // last handoff
    @(posedge clk_i);
    #3;
    check_registered();
    $display("checks=%0d value_errors=%0d assertion_errors=%0d handshakes=%0d",
             n_checks, n_errors, issue_read_operands_inst.checker_inst.fail_cnt, n_acks);
    if ((n_errors == 0) && (issue_read_operands_inst.checker_inst.fail_cnt == 0)) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns with %0d of %0d handshakes done",
             TIMEOUT_NS, n_acks, NUM_ACKS);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
issue_pkg.sv
int_regfile.sv
operand_lane.sv
issue_control.sv
issue_register.sv
issue_read_operands.sv
issue_read_operands_checker.sv
tb_issue_read_operands.sv

//--- Makefile
.PHONY: help test clean build

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator, run the simulation, check sim.log"
	@echo "  clean  remove build output and logs"

build:
	verilator --binary --timing --assert -f sources.f \
		--top-module tb_issue_read_operands -o Vtb_issue_read_operands

test: build
	./obj_dir/Vtb_issue_read_operands +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@grep -q "^TEST PASS$$" sim.log && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir sim.log
